// File: design/frame_board.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DIP decode, joystick map and LED
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "frame_defines.svh"

module frame_board
    import frame_pkg::*;
(
    input  logic       clk_sys,
    input  logic       sys_rst,
    input  status_t    status,
    input  board_joy_t joy1,
    input  board_joy_t joy2,
    input  logic [1:0] game_led,
    input  logic       downloading,
    // Game inputs
    output game_joy_t  game_joystick1,
    output game_joy_t  game_joystick2,
    output logic [1:0] game_coin,
    output logic [1:0] game_start,
    output logic       game_service,
    // DIP and options
    output logic       enable_fm,
    output logic       enable_psg,
    output logic       dip_test,
    output logic       dip_pause,
    output logic       dip_flip,
    output logic       rotate,
    output logic [1:0] dip_fxlevel,
    output dipsw_t     game_dipsw,
    output logic       led
);

    // Board stick bits past the game stick field
    localparam int JOY_COIN    = 10;
    localparam int JOY_START   = 11;
    localparam int JOY_SERVICE = 12;
    localparam int JOY_PAUSE   = 13;

    // Directions plus the buttons the game uses
    localparam game_joy_t JOY_MASK = game_joy_t'((1 << (4 + `BUTTONS)) - 1);
    localparam logic      INV      = `GAME_INPUTS_ACTIVE_LOW;

    logic                       pause_key;
    logic                       pause_q;
    logic                       pause_tog;
    logic [`LED_BLINK_BITS-1:0] blink_cnt;

    assign enable_fm   = ~status[`STS_NO_FM];
    assign enable_psg  = ~status[`STS_NO_PSG];
    assign dip_test    = status[`STS_TEST];
    assign dip_flip    = status[`STS_FLIP];
    assign rotate      = status[`STS_ROTATE];
    assign dip_fxlevel = status[`STS_FXLEVEL+1:`STS_FXLEVEL];
    assign game_dipsw  = status[`APB_DW-1:`STS_DIPBASE];

    // Mask unused buttons, then apply the game polarity
    assign game_joystick1 = (joy1[`JOY_GAME_W-1:0] & JOY_MASK) ^ {`JOY_GAME_W{INV}};
    assign game_joystick2 = (joy2[`JOY_GAME_W-1:0] & JOY_MASK) ^ {`JOY_GAME_W{INV}};
    assign game_coin      = {joy2[JOY_COIN], joy1[JOY_COIN]} ^ {2{INV}};
    assign game_start     = {joy2[JOY_START], joy1[JOY_START]} ^ {2{INV}};
    assign game_service   = (joy1[JOY_SERVICE] | joy2[JOY_SERVICE]) ^ INV;

    // Pause key from either player
    assign pause_key = joy1[JOY_PAUSE] | joy2[JOY_PAUSE];

    always_ff @(posedge clk_sys) begin
        if (sys_rst) begin
            pause_q   <= 1'b0;
            pause_tog <= 1'b0;
        end else begin
            pause_q <= pause_key;
            if (pause_key && !pause_q)
                pause_tog <= ~pause_tog;
        end
    end

    assign dip_pause = status[`STS_PAUSE] ^ pause_tog;

    // Free running blink counter
    always_ff @(posedge clk_sys) begin
        if (sys_rst)
            blink_cnt <= '0;
        else
            blink_cnt <= blink_cnt + 1'b1;
    end

    assign led = downloading ? blink_cnt[`LED_BLINK_BITS-1] : game_led[0];

endmodule

// File: design/frame_ctrl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB config registers, status and joysticks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "frame_defines.svh"

module frame_ctrl_regs
    import frame_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst,
    // APB slave
    input  apb_addr_t  paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    // Register outputs
    output status_t    status,
    output board_joy_t joy1,
    output board_joy_t joy2
);

    logic      access;
    logic      addr_hit;
    apb_data_t rd_data;

    // Access phase, no wait states
    assign access = psel && penable;

    // Address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            `ADDR_STATUS: rd_data = status;
            `ADDR_JOY1: begin
                rd_data = {{(`APB_DW-`JOY_BOARD_W){1'b0}}, joy1};
            end
            `ADDR_JOY2: begin
                rd_data = {{(`APB_DW-`JOY_BOARD_W){1'b0}}, joy2};
            end
            default: addr_hit = 1'b0;
        endcase
    end

    // Writes land on the edge closing the access phase
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            status <= '0;
            joy1   <= '0;
            joy2   <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                `ADDR_STATUS: status <= pwdata;
                `ADDR_JOY1:   joy1   <= pwdata[`JOY_BOARD_W-1:0];
                `ADDR_JOY2:   joy2   <= pwdata[`JOY_BOARD_W-1:0];
                default: ;
            endcase
        end
    end

    assign pready  = access;
    assign pslverr = access && !addr_hit;

    // Unmapped reads give zero through the default of the mux
    assign prdata  = (access && !pwrite) ? rd_data : '0;

endmodule

// File: design/frame_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board frame sizes, register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FRAME_DEFINES_SVH
`define FRAME_DEFINES_SVH

// Bus and data widths
`define APB_AW                 4
`define APB_DW                 32
`define JOY_BOARD_W            16
`define JOY_GAME_W             10
`define SND_W                  16

// Reset lengths in clk_sys cycles
`define RST_CYCLES             16
`define GAME_RST_CYCLES        8

// Game side options
`define LED_BLINK_BITS         4
`define BUTTONS                2
`define GAME_INPUTS_ACTIVE_LOW 1

// Register map
`define ADDR_STATUS            4'h0
`define ADDR_JOY1              4'h4
`define ADDR_JOY2              4'h8

// Status word fields, fxlevel takes two bits from here up
`define STS_FLIP               1
`define STS_ROTATE             2
`define STS_FXLEVEL            3
`define STS_NO_FM              5
`define STS_NO_PSG             6
`define STS_TEST               7
`define STS_PAUSE              8
`define STS_DIPBASE            16

`endif

// File: design/frame_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board frame shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "frame_defines.svh"

package frame_pkg;

    // APB side
    typedef logic [`APB_AW-1:0] apb_addr_t;
    typedef logic [`APB_DW-1:0] apb_data_t;

    // Status register is one full bus word
    typedef logic [`APB_DW-1:0] status_t;

    // Raw board stick: dirs 3..0, buttons 9..4, coin 10, start 11,
    // service 12, pause key 13
    typedef logic [`JOY_BOARD_W-1:0] board_joy_t;
    typedef logic [`JOY_GAME_W-1:0] game_joy_t;

    typedef logic [`SND_W-1:0] snd_sample_t;

    // Game DIP field sits in the upper part of the status word
    typedef logic [`APB_DW-`STS_DIPBASE-1:0] dipsw_t;

    // Board reset sequencer
    typedef enum logic [1:0] {
        RST_HOLD,
        RST_COUNT,
        RST_RUN
    } rst_state_t;

endpackage

// File: design/frame_reset.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board reset sequencer, game reset stretch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "frame_defines.svh"

module frame_reset
    import frame_pkg::*;
(
    input  logic clk_sys,
    input  logic rst,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic dip_flip,
    output logic sys_rst,
    output logic game_rst
);

    localparam int RST_CW  = $clog2(`RST_CYCLES + 1);
    localparam int GAME_CW = $clog2(`GAME_RST_CYCLES + 1);

    rst_state_t         state;
    logic [RST_CW-1:0]  rst_cnt;
    logic [GAME_CW-1:0] game_cnt;
    logic               flip_q;
    logic               game_cause;

    // Count starts on the first edge with both causes gone
    always_ff @(posedge clk_sys) begin
        if (rst || !pll_locked) begin
            state   <= RST_HOLD;
            rst_cnt <= '0;
        end else begin
            case (state)
                RST_HOLD: begin
                    state   <= RST_COUNT;
                    rst_cnt <= RST_CW'(1);
                end
                RST_COUNT: begin
                    if (rst_cnt == RST_CW'(`RST_CYCLES - 1))
                        state <= RST_RUN;
                    else
                        rst_cnt <= rst_cnt + 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign sys_rst = (state != RST_RUN);

    // A flip change restarts the game
    assign game_cause = sys_rst || rst_req || downloading || (dip_flip != flip_q);

    // Reload on every cause, then run down
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            flip_q   <= 1'b0;
            game_cnt <= GAME_CW'(`GAME_RST_CYCLES);
        end else begin
            flip_q <= dip_flip;
            if (game_cause)
                game_cnt <= GAME_CW'(`GAME_RST_CYCLES);
            else if (game_cnt != '0)
                game_cnt <= game_cnt - 1'b1;
        end
    end

    assign game_rst = game_cause || (game_cnt != '0);

endmodule

// File: design/frame_snd_dac.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First order sigma-delta DAC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "frame_defines.svh"

module frame_snd_dac
    import frame_pkg::*;
(
    input  logic        clk_sys,
    input  logic        sys_rst,
    input  snd_sample_t sample,
    output logic        pdm
);

    // Top bit holds the carry of the last add
    logic [`SND_W:0] acc;

    always_ff @(posedge clk_sys) begin
        if (sys_rst) begin
            acc <= '0;
            pdm <= 1'b0;
        end else begin
            // Only the residue is fed back
            acc <= {1'b0, acc[`SND_W-1:0]} + {1'b0, sample};
            pdm <= acc[`SND_W];
        end
    end

endmodule

// File: design/neptuno_frame.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NeptUNO board frame top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "frame_defines.svh"

module neptuno_frame
    import frame_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst,
    input  logic        pll_locked,
    input  logic        rst_req,
    input  logic        downloading,
    input  logic [1:0]  game_led,
    // APB from the microcontroller
    input  apb_addr_t   paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,
    output logic        pready,
    output logic        pslverr,
    // Sound
    input  snd_sample_t snd_left,
    input  snd_sample_t snd_right,
    // Game side
    output logic        game_rst,
    output game_joy_t   game_joystick1,
    output game_joy_t   game_joystick2,
    output logic [1:0]  game_coin,
    output logic [1:0]  game_start,
    output logic        game_service,
    output logic        enable_fm,
    output logic        enable_psg,
    output logic        dip_test,
    output logic        dip_pause,
    output logic        dip_flip,
    output logic        rotate,
    output logic [1:0]  dip_fxlevel,
    output dipsw_t      game_dipsw,
    output logic        led,
    output logic        audio_l,
    output logic        audio_r
);

    status_t    status;
    board_joy_t joy1;
    board_joy_t joy2;
    logic       sys_rst;

    // Config registers run on the raw reset
    frame_ctrl_regs u_regs (
        .clk_sys ( clk_sys ),
        .rst     ( rst     ),
        .paddr   ( paddr   ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .pslverr ( pslverr ),
        .status  ( status  ),
        .joy1    ( joy1    ),
        .joy2    ( joy2    )
    );

    frame_reset u_reset (
        .clk_sys     ( clk_sys              ),
        .rst         ( rst                  ),
        .pll_locked  ( pll_locked           ),
        .rst_req     ( rst_req              ),
        .downloading ( downloading          ),
        .dip_flip    ( status[`STS_FLIP]    ),
        .sys_rst     ( sys_rst              ),
        .game_rst    ( game_rst             )
    );

    frame_board u_board (
        .clk_sys        ( clk_sys        ),
        .sys_rst        ( sys_rst        ),
        .status         ( status         ),
        .joy1           ( joy1           ),
        .joy2           ( joy2           ),
        .game_led       ( game_led       ),
        .downloading    ( downloading    ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_service   ( game_service   ),
        .enable_fm      ( enable_fm      ),
        .enable_psg     ( enable_psg     ),
        .dip_test       ( dip_test       ),
        .dip_pause      ( dip_pause      ),
        .dip_flip       ( dip_flip       ),
        .rotate         ( rotate         ),
        .dip_fxlevel    ( dip_fxlevel    ),
        .game_dipsw     ( game_dipsw     ),
        .led            ( led            )
    );

    // One DAC per channel
    frame_snd_dac u_dac_l (
        .clk_sys ( clk_sys  ),
        .sys_rst ( sys_rst  ),
        .sample  ( snd_left ),
        .pdm     ( audio_l  )
    );

    frame_snd_dac u_dac_r (
        .clk_sys ( clk_sys   ),
        .sys_rst ( sys_rst   ),
        .sample  ( snd_right ),
        .pdm     ( audio_r   )
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the frame testbench with Verilator, run from the project root
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_neptuno_frame -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "All tests passed!" sim.log && exit 0 || exit 1

// File: src.f
+incdir+design
design/frame_pkg.sv
design/frame_ctrl_regs.sv
design/frame_reset.sv
design/frame_board.sv
design/frame_snd_dac.sv
design/neptuno_frame.sv
verif/frame_assert.sv
verif/tb_neptuno_frame.sv

// File: verif/frame_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame checks on APB and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "frame_defines.svh"

module frame_assert
    import frame_pkg::*;
(
    input logic      clk_sys,
    input logic      rst,
    input logic      psel,
    input logic      penable,
    input logic      pwrite,
    input apb_data_t prdata,
    input logic      pslverr,
    input logic      sys_rst,
    input logic      game_rst
);

    // Error response only in an access phase and with zero read data
    a_slverr_phase: assert property (@(posedge clk_sys)
        pslverr |-> (psel && penable && (pwrite || prdata == '0)))
        else $error("pslverr outside an access phase or with nonzero read data");

    // Game reset outlasts the board reset by the stretch
    a_game_rst: assert property (@(posedge clk_sys)
        $past(sys_rst, `GAME_RST_CYCLES) |-> game_rst)
        else $error("game_rst not held for the stretch after sys_rst");

    a_sys_rst: assert property (@(posedge clk_sys) rst |=> sys_rst)
        else $error("sys_rst not high in the edge after rst");

endmodule

bind neptuno_frame frame_assert u_frame_assert (
    .clk_sys  ( clk_sys  ),
    .rst      ( rst      ),
    .psel     ( psel     ),
    .penable  ( penable  ),
    .pwrite   ( pwrite   ),
    .prdata   ( prdata   ),
    .pslverr  ( pslverr  ),
    .sys_rst  ( sys_rst  ),
    .game_rst ( game_rst )
);

// File: verif/frame_input.txt
# op sel data exp, hex. W: exp=pslverr. R: data=pslverr, exp=prdata. T: sel=test number
# P: set pin (f = idle cycles). C: check output sel. G: game_rst edges. L: led toggles. A: ones
T 1 0 0
C 0 0 3ff
C 1 0 3ff
C d 0 0
C e 0 0
C f 0 0
P 0 0 0
G 0 0 18
T 2 0 0
W 0 12345678 0
R 0 0 12345678
W 4 ffff1bcd 0
R 4 0 1bcd
W c 5a5a5a5a 1
R c 1 0
R 8 0 0
T 3 0 0
W 0 1e5a015e 0
C 5 0 1
C 6 0 0
C 7 0 0
C 8 0 1
C 9 0 1
C a 0 1
C b 0 3
C c 0 1e5a
T 4 0 0
J 0 10 0
W 0 0 0
W 4 2000 0
P f 2 0
C 8 0 1
W 4 0 0
W 4 2000 0
P f 2 0
C 8 0 0
T 5 0 0
P 1 1 0
P f 2 0
P 1 0 0
G 0 0 8
P 2 1 0
L 0 20 4
P 2 0 0
G 0 0 8
W 0 2 0
G 0 0 9
P 3 1 0
C d 0 1
T 6 0 0
P 0 1 0
P f 5 0
P 0 0 0
P f 14 0
A 0 3039 c350

// File: verif/tb_neptuno_frame.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board frame testbench, vector driven
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "frame_defines.svh"

module tb_neptuno_frame
    import frame_pkg::*;
();

    localparam int         CLK_HALF   = 20;
    // Two DAC windows of 65536 cycles plus the short tests
    localparam int         MAX_CYCLES = 140000;
    localparam logic       INV_BIT    = `GAME_INPUTS_ACTIVE_LOW;

    logic clk_sys = 1'b0;
    logic rst, pll_locked, rst_req, downloading;
    logic [1:0] game_led;
    apb_addr_t paddr;
    logic psel, penable, pwrite;
    apb_data_t pwdata, prdata;
    logic pready, pslverr;
    snd_sample_t snd_left, snd_right;
    logic game_rst, game_service, enable_fm, enable_psg, dip_test, dip_pause;
    game_joy_t game_joystick1, game_joystick2;
    logic [1:0] game_coin, game_start, dip_fxlevel;
    logic dip_flip, rotate, led, audio_l, audio_r;
    dipsw_t game_dipsw;

    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int test_num = 0;
    int test_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] rnd;

    neptuno_frame i_neptuno_frame (.*);

    always #CLK_HALF clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run stopped, no progress after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Four directions, then the buttons in use, the rest at the idle level
    function automatic logic [9:0] game_stick(input logic [15:0] w);
        logic [9:0] s;
        for (int i = 0; i < 10; i++) begin
            if (i < 4 + `BUTTONS)
                s[i] = w[i] ^ INV_BIT;
            else
                s[i] = INV_BIT;
        end
        return s;
    endfunction

    // Setup and access phase, values sampled mid access
    task automatic apb_access(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                              input logic exp_err, input logic [31:0] exp_rdata);
        @(negedge clk_sys);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_sys);
        penable = 1'b1;
        #(CLK_HALF / 2);
        check_val("pready", pready, 32'd1);
        check_val("pslverr", pslverr, exp_err);
        if (!wr)
            check_val("prdata", prdata, exp_rdata);
        @(negedge clk_sys);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic set_pin(input logic [31:0] sel, input logic [31:0] val);
        case (sel)
            0: rst = val[0];
            1: rst_req = val[0];
            2: downloading = val[0];
            3: game_led = val[1:0];
            4: pll_locked = val[0];
            'hf: repeat (val) @(negedge clk_sys);
            default: begin
                $display("ERROR: unknown pin selector %0h", sel);
                errors++;
                test_errs++;
            end
        endcase
    endtask

    task automatic check_out(input logic [31:0] sel, input logic [31:0] exp);
        // Outputs settle by the next falling edge
        @(negedge clk_sys);
        case (sel)
            'h0: check_val("game_joystick1", game_joystick1, exp);
            'h1: check_val("game_joystick2", game_joystick2, exp);
            'h2: check_val("game_coin", game_coin, exp);
            'h3: check_val("game_start", game_start, exp);
            'h4: check_val("game_service", game_service, exp);
            'h5: check_val("enable_fm", enable_fm, exp);
            'h6: check_val("enable_psg", enable_psg, exp);
            'h7: check_val("dip_test", dip_test, exp);
            'h8: check_val("dip_pause", dip_pause, exp);
            'h9: check_val("dip_flip", dip_flip, exp);
            'ha: check_val("rotate", rotate, exp);
            'hb: check_val("dip_fxlevel", dip_fxlevel, exp);
            'hc: check_val("game_dipsw", game_dipsw, exp);
            'hd: check_val("led", led, exp);
            'he: check_val("audio_l", audio_l, exp);
            'hf: check_val("audio_r", audio_r, exp);
            default: check_val("game_rst", game_rst, exp);
        endcase
    endtask

    // Active low game inputs, unused buttons held inactive
    task automatic random_joy(input int count);
        logic [15:0] w1;
        logic [15:0] w2;
        for (int i = 0; i < count; i++) begin
            rnd = lcg_next(rnd);
            w1  = rnd[31:16] & 16'hdfff;
            rnd = lcg_next(rnd);
            w2  = rnd[31:16] & 16'hdfff;
            apb_access(`ADDR_JOY1, 1'b1, {16'h0, w1}, 1'b0, '0);
            apb_access(`ADDR_JOY2, 1'b1, {16'h0, w2}, 1'b0, '0);
            check_val("game_joystick1", game_joystick1, game_stick(w1));
            check_val("game_joystick2", game_joystick2, game_stick(w2));
            check_val("game_coin", game_coin, {w2[10], w1[10]} ^ {2{INV_BIT}});
            check_val("game_start", game_start, {w2[11], w1[11]} ^ {2{INV_BIT}});
            check_val("game_service", game_service, (w1[12] | w2[12]) ^ INV_BIT);
        end
    endtask

    task automatic count_game_rst(input logic [31:0] exp);
        int n;
        n = 0;
        while (game_rst) begin
            @(negedge clk_sys);
            n++;
        end
        check_val("game_rst edges", n, exp);
    endtask

    task automatic count_led(input int ncyc, input logic [31:0] exp);
        int toggles;
        logic prev;
        toggles = 0;
        // Start from a settled led value
        @(negedge clk_sys);
        prev = led;
        repeat (ncyc) begin
            @(negedge clk_sys);
            if (led != prev)
                toggles++;
            prev = led;
        end
        check_val("led toggles", toggles, exp);
    endtask

    task automatic run_audio(input logic [31:0] left, input logic [31:0] right);
        int ones_l;
        int ones_r;
        ones_l    = 0;
        ones_r    = 0;
        snd_left  = left[15:0];
        snd_right = right[15:0];
        // First add of the new sample reaches pdm two edges later
        repeat (2) @(negedge clk_sys);
        repeat (65536) begin
            @(negedge clk_sys);
            ones_l += audio_l;
            ones_r += audio_r;
        end
        check_val("audio_l ones", ones_l, left);
        check_val("audio_r ones", ones_r, right);
    endtask

    task automatic finish_test();
        if (test_num > 0) begin
            if (test_errs == 0) begin
                $display("Test %0d passed", test_num);
            end else begin
                $display("Test %0d failed with %0d errors", test_num, test_errs);
                tests_failed++;
            end
        end
    endtask

    initial begin
        int fd;
        int n;
        string line;
        byte op;
        logic [31:0] sel, data, exp;
        rst = 1'b1;
        pll_locked = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        game_led = 2'b00;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        snd_left = '0;
        snd_right = '0;
        rnd = 32'd45526;
        repeat (5) @(negedge clk_sys);
        fd = $fopen("verif/frame_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: vector file verif/frame_input.txt could not be opened");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0)
                n = $sscanf(line, "%c %h %h %h", op, sel, data, exp);
            if (n == 4 && op != "#") begin
                case (op)
                    "T": begin
                        finish_test();
                        test_num = sel;
                        test_errs = 0;
                        tests_run++;
                    end
                    "W": apb_access(sel[3:0], 1'b1, data, exp[0], '0);
                    "R": apb_access(sel[3:0], 1'b0, '0, data[0], exp);
                    "P": set_pin(sel, data);
                    "C": check_out(sel, exp);
                    "G": count_game_rst(exp);
                    "L": count_led(data, exp);
                    "J": random_joy(data);
                    "A": run_audio(data, exp);
                    default: begin
                        $display("ERROR: unknown opcode %c in vector file", op);
                        errors++;
                    end
                endcase
            end
        end
        finish_test();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
